//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := codec_cfg_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+source
source/codec_regs_pkg.sv
source/i2c_bus_pkg.sv
source/codec_cfg_seq.sv
source/i2c_write_frame.sv
source/i2c_bit_phy.sv
source/codec_cfg_top.sv
tb/codec_cfg_assertions.sv
tb/codec_cfg_tb.sv

//--- source/codec_cfg_seq.sv
`include "codec_settings.svh"

module codec_cfg_seq (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr_done,
    input  logic                      wr_nack,
    output logic                      wr_req,
    output codec_regs_pkg::reg_addr_t wr_addr,
    output codec_regs_pkg::reg_data_t wr_data,
    output logic                      cfg_done,
    output logic                      cfg_error
);
    import codec_regs_pkg::*;

    localparam int unsigned DW = `CODEC_DELAY_W;

    // Counter end values for the two waits
    localparam logic [DW-1:0] POWERUP_LAST = DW'(`CODEC_POWERUP_CYCLES - 1);
    localparam logic [DW-1:0] PAUSE_LAST   = DW'(`CODEC_RESET_WAIT_CYCLES - 1);

    // Soft-reset release entry and last entry
    localparam reg_index_t RESET_INDEX = reg_index_t'(1);
    localparam reg_index_t LAST_INDEX  = reg_index_t'(28);

    // Fixed format fields
    localparam wl_code_t  WL     = wl_code_of(`CODEC_WORD_LEN);
    localparam reg_data_t VOLUME = reg_data_t'(`CODEC_VOLUME);

    seq_state_t      state;
    reg_index_t      idx;
    logic [DW-1:0]   delay_cnt;

    // --------------------
    // Sequencer FSM
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= POWERUP;
            idx       <= '0;
            delay_cnt <= '0;
        end else begin
            case (state)
                // Let the codec supply settle
                POWERUP: begin
                    if (delay_cnt == POWERUP_LAST) begin
                        delay_cnt <= '0;
                        state     <= ISSUE;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                // One-cycle request
                ISSUE: state <= WAIT_DONE;
                WAIT_DONE: begin
                    if (wr_done) begin
                        if (wr_nack) begin
                            state <= ERROR;
                        end else if (idx == LAST_INDEX) begin
                            state <= DONE;
                        end else begin
                            idx   <= idx + 1'b1;
                            // Codec needs time after soft reset
                            state <= (idx == RESET_INDEX) ? RESET_PAUSE : ISSUE;
                        end
                    end
                end
                RESET_PAUSE: begin
                    if (delay_cnt == PAUSE_LAST) begin
                        delay_cnt <= '0;
                        state     <= ISSUE;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                // Terminal until reset
                DONE, ERROR: state <= state;
                default: state <= POWERUP;
            endcase
        end
    end

    assign wr_req    = (state == ISSUE);
    assign cfg_done  = (state == DONE);
    assign cfg_error = (state == ERROR);

    // --------------------
    // Register table
    // --------------------
    always_comb begin
        case (idx)
            // Soft reset on, then off
            5'd0:  {wr_addr, wr_data} = {8'h00, 8'h80};
            5'd1:  {wr_addr, wr_data} = {8'h00, 8'h00};
            5'd2:  {wr_addr, wr_data} = {8'h01, 8'h58};
            5'd3:  {wr_addr, wr_data} = {8'h01, 8'h50};
            // Chip power management
            5'd4:  {wr_addr, wr_data} = {8'h02, 8'hF3};
            5'd5:  {wr_addr, wr_data} = {8'h02, 8'h00};
            5'd6:  {wr_addr, wr_data} = {8'h03, 8'h09};
            5'd7:  {wr_addr, wr_data} = {8'h00, 8'h06};
            5'd8:  {wr_addr, wr_data} = {8'h04, 8'h3C};
            // Slave mode, mic gain, input select
            5'd9:  {wr_addr, wr_data} = {8'h08, 8'h00};
            5'd10: {wr_addr, wr_data} = {8'h09, 8'h77};
            5'd11: {wr_addr, wr_data} = {8'h0A, 8'h00};
            // ADC format, I2S with word length
            5'd12: {wr_addr, wr_data} = {8'h0C, 2'b01, 1'b0, WL, 2'b00};
            5'd13: {wr_addr, wr_data} = {8'h0D, 8'h0C};
            5'd14: {wr_addr, wr_data} = {8'h10, 8'h00};
            5'd15: {wr_addr, wr_data} = {8'h11, 8'h00};
            // ALC setup
            5'd16: {wr_addr, wr_data} = {8'h12, 8'hDB};
            // DAC format, I2S with word length
            5'd17: {wr_addr, wr_data} = {8'h17, 2'b00, WL, 3'b000};
            5'd18: {wr_addr, wr_data} = {8'h18, 8'h0C};
            5'd19: {wr_addr, wr_data} = {8'h1A, 8'h0A};
            5'd20: {wr_addr, wr_data} = {8'h1B, 8'h0A};
            5'd21: {wr_addr, wr_data} = {8'h1D, 8'h1C};
            // Output mixers and shared LRCK
            5'd22: {wr_addr, wr_data} = {8'h27, 8'hF8};
            5'd23: {wr_addr, wr_data} = {8'h2A, 8'hF8};
            5'd24: {wr_addr, wr_data} = {8'h2B, 8'h80};
            // Headphone then speaker volume
            5'd25: {wr_addr, wr_data} = {8'h2E, VOLUME};
            5'd26: {wr_addr, wr_data} = {8'h2F, VOLUME};
            5'd27: {wr_addr, wr_data} = {8'h30, VOLUME};
            5'd28: {wr_addr, wr_data} = {8'h31, VOLUME};
            default: {wr_addr, wr_data} = 16'h0000;
        endcase
    end

endmodule

//--- source/codec_cfg_top.sv
module codec_cfg_top (
    input  logic clk,
    input  logic rst_n,
    input  logic sda_in,
    output logic scl,
    output logic sda_oe,
    output logic cfg_done,
    output logic cfg_error
);
    import codec_regs_pkg::*;
    import i2c_bus_pkg::*;

    // Sequencer to frame stage
    logic      wr_req;
    reg_addr_t wr_addr;
    reg_data_t wr_data;
    logic      wr_done;
    logic      wr_nack;

    // Frame stage to bit stage
    logic      cmd_valid;
    i2c_cmd_t  cmd;
    logic      cmd_bit;
    logic      cmd_done;
    logic      rx_bit;

    codec_cfg_seq i_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_done   (wr_done),
        .wr_nack   (wr_nack),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .cfg_done  (cfg_done),
        .cfg_error (cfg_error)
    );

    i2c_write_frame i_frame (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_done   (wr_done),
        .wr_nack   (wr_nack),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_bit   (cmd_bit),
        .cmd_done  (cmd_done),
        .rx_bit    (rx_bit)
    );

    i2c_bit_phy i_phy (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_bit   (cmd_bit),
        .cmd_done  (cmd_done),
        .rx_bit    (rx_bit),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule

//--- source/codec_regs_pkg.sv
package codec_regs_pkg;

    // --------------------
    // Register-side widths
    // --------------------

    // Codec register address and value
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // Position in the write table, 29 entries
    typedef logic [4:0] reg_index_t;

    // Word-length field as used by R12 and R23
    typedef logic [2:0] wl_code_t;

    // Sequencer FSM
    typedef enum logic [2:0] {
        POWERUP,
        ISSUE,
        WAIT_DONE,
        RESET_PAUSE,
        DONE,
        ERROR
    } seq_state_t;

    // Word length in bits to codec code
    // Unsupported lengths fall back to the 24-bit code
    function automatic wl_code_t wl_code_of(input int unsigned word_len);
        case (word_len)
            16:      wl_code_of = 3'd3;
            18:      wl_code_of = 3'd2;
            20:      wl_code_of = 3'd1;
            24:      wl_code_of = 3'd0;
            32:      wl_code_of = 3'd4;
            default: wl_code_of = 3'd0;
        endcase
    endfunction

endpackage

//--- source/codec_settings.svh
`ifndef CODEC_SETTINGS_SVH
`define CODEC_SETTINGS_SVH

// --------------------
// I2C bus
// --------------------

// Seven-bit codec device address
`define CODEC_I2C_ADDR 7'h10

// Clock cycles per quarter of an SCL period
`define CODEC_SCL_QUARTER 4

// --------------------
// Sequencer delays
// --------------------

// Cycles from reset release to the first register write
`define CODEC_POWERUP_CYCLES 32

// Pause after the soft-reset release write
`define CODEC_RESET_WAIT_CYCLES 200

// Delay counter width, must hold both delays above
`define CODEC_DELAY_W 8

// --------------------
// Audio format
// --------------------

// Word length in bits: 16, 18, 20, 24 or 32
`define CODEC_WORD_LEN 16

// Headphone and speaker volume, 0 to 33
`define CODEC_VOLUME 30

`endif

//--- source/i2c_bit_phy.sv
`include "codec_settings.svh"

module i2c_bit_phy (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    input  i2c_bus_pkg::i2c_cmd_t cmd,
    input  logic                  cmd_bit,
    output logic                  cmd_done,
    output logic                  rx_bit,
    output logic                  scl,
    output logic                  sda_oe,
    input  logic                  sda_in
);
    import i2c_bus_pkg::*;

    localparam int unsigned Q  = `CODEC_SCL_QUARTER;
    localparam int unsigned QW = $clog2(Q + 1);
    localparam logic [QW-1:0] Q_LAST = QW'(Q - 1);

    phy_state_t      state;
    logic [QW-1:0]   qcnt;
    logic [1:0]      phase;
    i2c_cmd_t        cmd_q;
    logic            bit_q;

    // Line levels per quarter, returned as {scl, sda_oe}
    function automatic logic [1:0] bus_levels(input i2c_cmd_t c, input logic b,
                                              input logic [1:0] ph);
        case (c)
            // SDA falls in quarter 1 with SCL high
            CMD_START:     bus_levels = {ph < 2'd2, ph != 2'd0};
            // SDA rises in quarter 2 with SCL high
            CMD_STOP:      bus_levels = {ph != 2'd0, ph < 2'd2};
            CMD_WRITE_BIT: bus_levels = {ph == 2'd1 || ph == 2'd2, ~b};
            default:       bus_levels = {ph == 2'd1 || ph == 2'd2, 1'b0};
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= PHY_IDLE;
            qcnt   <= '0;
            phase  <= '0;
            // Bus looks as after a stop
            cmd_q  <= CMD_STOP;
            bit_q  <= 1'b0;
            scl    <= 1'b1;
            sda_oe <= 1'b0;
            rx_bit <= 1'b0;
        end else begin
            case (state)
                PHY_IDLE: begin
                    if (cmd_valid) begin
                        state <= PHY_RUN;
                        qcnt  <= '0;
                        phase <= '0;
                        cmd_q <= cmd;
                        bit_q <= cmd_bit;
                        {scl, sda_oe} <= bus_levels(cmd, cmd_bit, 2'd0);
                    end
                end
                PHY_RUN: begin
                    // Sample at end of first high quarter
                    if (cmd_q == CMD_READ_BIT && phase == 2'd1 && qcnt == Q_LAST) begin
                        rx_bit <= sda_in;
                    end
                    if (qcnt == Q_LAST) begin
                        qcnt  <= '0;
                        phase <= phase + 1'b1;
                        if (phase == 2'd3) begin
                            // Lines hold until next command
                            state <= PHY_IDLE;
                        end else begin
                            {scl, sda_oe} <= bus_levels(cmd_q, bit_q, phase + 2'd1);
                        end
                    end else begin
                        qcnt <= qcnt + 1'b1;
                    end
                end
                default: state <= PHY_IDLE;
            endcase
        end
    end

    // Last cycle of the fourth quarter
    assign cmd_done = (state == PHY_RUN) && (phase == 2'd3) && (qcnt == Q_LAST);

endmodule

//--- source/i2c_bus_pkg.sv
package i2c_bus_pkg;

    // Seven-bit device address on the wire
    typedef logic [6:0] dev_addr_t;

    // Bit-level command from frame stage to bit stage
    typedef logic [1:0] i2c_cmd_t;

    localparam i2c_cmd_t CMD_START     = 2'd0;
    localparam i2c_cmd_t CMD_STOP      = 2'd1;
    localparam i2c_cmd_t CMD_WRITE_BIT = 2'd2;
    localparam i2c_cmd_t CMD_READ_BIT  = 2'd3;

    // Frame stage FSM
    typedef enum logic [2:0] {
        FRM_IDLE,
        FRM_SEND_START,
        FRM_SEND_BITS,
        FRM_GET_ACK,
        FRM_SEND_STOP
    } frame_state_t;

    // Bit stage FSM
    typedef enum logic {
        PHY_IDLE,
        PHY_RUN
    } phy_state_t;

endpackage

//--- source/i2c_write_frame.sv
`include "codec_settings.svh"

module i2c_write_frame (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr_req,
    input  codec_regs_pkg::reg_addr_t wr_addr,
    input  codec_regs_pkg::reg_data_t wr_data,
    output logic                      wr_done,
    output logic                      wr_nack,
    output logic                      cmd_valid,
    output i2c_bus_pkg::i2c_cmd_t     cmd,
    output logic                      cmd_bit,
    input  logic                      cmd_done,
    input  logic                      rx_bit
);
    import codec_regs_pkg::*;
    import i2c_bus_pkg::*;

    localparam dev_addr_t DEV_ADDR = `CODEC_I2C_ADDR;

    frame_state_t state;
    // Device byte, register byte, data byte, MSB first
    logic [23:0]  frame_sh;
    logic [2:0]   bit_cnt;
    logic [1:0]   byte_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= FRM_IDLE;
            frame_sh  <= '0;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
            cmd_valid <= 1'b0;
            cmd       <= CMD_STOP;
            cmd_bit   <= 1'b0;
            wr_done   <= 1'b0;
            wr_nack   <= 1'b0;
        end else begin
            // Pulses by default
            cmd_valid <= 1'b0;
            wr_done   <= 1'b0;
            case (state)
                FRM_IDLE: begin
                    if (wr_req) begin
                        // Write bit is zero
                        frame_sh  <= {DEV_ADDR, 1'b0, wr_addr, wr_data};
                        bit_cnt   <= '0;
                        byte_cnt  <= '0;
                        wr_nack   <= 1'b0;
                        cmd_valid <= 1'b1;
                        cmd       <= CMD_START;
                        state     <= FRM_SEND_START;
                    end
                end
                FRM_SEND_START: begin
                    if (cmd_done) begin
                        cmd_valid <= 1'b1;
                        cmd       <= CMD_WRITE_BIT;
                        cmd_bit   <= frame_sh[23];
                        state     <= FRM_SEND_BITS;
                    end
                end
                FRM_SEND_BITS: begin
                    if (cmd_done) begin
                        frame_sh  <= {frame_sh[22:0], 1'b0};
                        cmd_valid <= 1'b1;
                        if (bit_cnt == 3'd7) begin
                            // Release SDA for the slave ACK
                            cmd     <= CMD_READ_BIT;
                            cmd_bit <= 1'b1;
                            state   <= FRM_GET_ACK;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            cmd     <= CMD_WRITE_BIT;
                            cmd_bit <= frame_sh[22];
                        end
                    end
                end
                FRM_GET_ACK: begin
                    if (cmd_done) begin
                        cmd_valid <= 1'b1;
                        // High ACK slot means NACK, abort to stop
                        if (rx_bit || byte_cnt == 2'd2) begin
                            wr_nack <= rx_bit;
                            cmd     <= CMD_STOP;
                            state   <= FRM_SEND_STOP;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            bit_cnt  <= '0;
                            cmd      <= CMD_WRITE_BIT;
                            cmd_bit  <= frame_sh[23];
                            state    <= FRM_SEND_BITS;
                        end
                    end
                end
                FRM_SEND_STOP: begin
                    if (cmd_done) begin
                        wr_done <= 1'b1;
                        state   <= FRM_IDLE;
                    end
                end
                default: state <= FRM_IDLE;
            endcase
        end
    end

endmodule

//--- tb/codec_cfg_assertions.sv
module codec_cfg_assertions (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  scl,
    input logic                  sda_oe,
    input logic                  cmd_valid,
    input i2c_bus_pkg::i2c_cmd_t cmd,
    input logic                  cmd_done,
    input logic                  wr_req,
    input logic                  wr_done,
    input logic                  cfg_done,
    input logic                  cfg_error
);
    timeunit 1ns;
    timeprecision 100ps;
    import i2c_bus_pkg::*;

    // Sticky failure flags
    logic     sda_err  = 1'b0;
    logic     flag_err = 1'b0;
    logic     req_err  = 1'b0;
    logic     idle_err = 1'b0;
    logic     failed;

    i2c_cmd_t cur_cmd;
    logic     busy;
    logic     pending;

    // --------------------
    // Bit stage and handshake tracking
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_cmd <= CMD_STOP;
            busy    <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (cmd_valid) begin
                cur_cmd <= cmd;
                busy    <= 1'b1;
            end else if (cmd_done) begin
                busy <= 1'b0;
            end
            // Write request open until its done pulse
            if (wr_req) begin
                pending <= 1'b1;
            end else if (wr_done) begin
                pending <= 1'b0;
            end
        end
    end

    assign failed = sda_err | flag_err | req_err | idle_err;

    // SDA moves under high SCL only for start and stop
    sda_edge_ok: assert property (@(posedge clk) disable iff (!rst_n)
        (scl && $past(scl) && sda_oe != $past(sda_oe)) |->
            (cur_cmd == CMD_START || cur_cmd == CMD_STOP))
    else begin
        sda_err = 1'b1;
        $error("SDA enable changed while SCL was high outside start or stop");
    end

    // End flags hold until reset so done and error never meet
    end_flags_ok: assert property (@(posedge clk) disable iff (!rst_n)
        (cfg_done || cfg_error) |=> $stable({cfg_done, cfg_error}))
    else begin
        flag_err = 1'b1;
        $error("An end flag changed before reset");
    end

    req_order_ok: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req |-> !pending)
    else begin
        req_err = 1'b1;
        $error("Write request repeated before the previous write finished");
    end

    // Released bus after a stop
    idle_bus_ok: assert property (@(posedge clk) disable iff (!rst_n)
        (!busy && cur_cmd == CMD_STOP) |-> (scl && !sda_oe))
    else begin
        idle_err = 1'b1;
        $error("Bus not released while the bit stage was idle");
    end

endmodule

// Checker instance inside the configuration top
bind codec_cfg_top codec_cfg_assertions u_checks (
    .clk       (clk),
    .rst_n     (rst_n),
    .scl       (scl),
    .sda_oe    (sda_oe),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_done  (cmd_done),
    .wr_req    (wr_req),
    .wr_done   (wr_done),
    .cfg_done  (cfg_done),
    .cfg_error (cfg_error)
);

//--- tb/codec_cfg_tb.sv
`include "codec_settings.svh"

module codec_cfg_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int     CLK_PERIOD  = 100;
    localparam int     POWERUP     = `CODEC_POWERUP_CYCLES;
    localparam int     RESET_WAIT  = `CODEC_RESET_WAIT_CYCLES;
    localparam int     NUM_WRITES  = 29;
    localparam int     END_TIMEOUT = 40000;
    localparam int     IDLE_WATCH  = 1200;

    // Codec write table, data bytes of 12, 17 and 25 to 28 filled in later
    localparam logic [15:0] BASE_TABLE [0:28] = '{
        16'h0080, 16'h0000, 16'h0158, 16'h0150, 16'h02F3, 16'h0200, 16'h0309, 16'h0006,
        16'h043C, 16'h0800, 16'h0977, 16'h0A00, 16'h0C00, 16'h0D0C, 16'h1000, 16'h1100,
        16'h12DB, 16'h1700, 16'h180C, 16'h1A0A, 16'h1B0A, 16'h1D1C, 16'h27F8, 16'h2AF8,
        16'h2B80, 16'h2E00, 16'h2F00, 16'h3000, 16'h3100
    };

    logic clk;
    logic rst_n;
    logic sda_in;
    logic scl;
    logic sda_oe;
    logic cfg_done;
    logic cfg_error;

    // Slave model state
    logic        scl_prev;
    logic        line_prev;
    logic        line_now;
    logic        pull;
    logic        in_ack;
    logic        in_frame;
    logic [7:0]  shreg;
    logic [23:0] frame_bytes;
    int          bit_cnt;
    int          byte_cnt;
    int          frame_num;

    // Captured frames and their bus times
    logic [23:0] cap_bytes[$];
    int          cap_len[$];
    longint      start_times[$];
    longint      stop_times[$];

    // NACK injection and expected sequence end
    bit          nack_armed;
    int          nack_index;
    int          nack_byte;
    int          last_index;
    int          frames_seen;
    integer      seed;
    longint      rel_time;
    longint      gap;

    codec_cfg_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .sda_in    (sda_in),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .cfg_done  (cfg_done),
        .cfg_error (cfg_error)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // Reference model
    // --------------------

    // Word length in bits to codec code
    function automatic int wl_code_for(input int bits);
        case (bits)
            16:      return 3;
            18:      return 2;
            20:      return 1;
            24:      return 0;
            32:      return 4;
            default: return 0;
        endcase
    endfunction

    // Address/data pair of one table entry
    function automatic logic [15:0] expected_write(input int index);
        logic [15:0] pair;
        int          wl;
        wl   = wl_code_for(`CODEC_WORD_LEN);
        pair = BASE_TABLE[index];
        case (index)
            12:             pair[7:0] = 8'(8'h40 + wl * 4);
            17:             pair[7:0] = 8'(wl * 8);
            25, 26, 27, 28: pair[7:0] = 8'(`CODEC_VOLUME);
            default:        ;
        endcase
        return pair;
    endfunction

    // --------------------
    // Checks
    // --------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("Mismatch on %s: got 0x%08h, expected 0x%08h",
                                     name, got, expected));
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        rst_n    = 1'b1;
        rel_time = $time;
    endtask

    task automatic check_idle_outputs();
        check_value("scl", 32'(scl), 32'd1);
        check_value("sda_oe", 32'(sda_oe), 32'd0);
        check_value("cfg_done", 32'(cfg_done), 32'd0);
        check_value("cfg_error", 32'(cfg_error), 32'd0);
    endtask

    // Poll for either end flag
    task automatic wait_for_end();
        int cycles;
        cycles = 0;
        while (!cfg_done && !cfg_error) begin
            @(negedge clk);
            cycles++;
            if (cycles > END_TIMEOUT) begin
                report_failure("Timed out waiting for the configuration to finish");
            end
        end
    endtask

    // Flags must hold and the bus must stay quiet
    task automatic watch_idle(input logic exp_done, input logic exp_error, input int exp_frames);
        repeat (IDLE_WATCH) begin
            @(negedge clk);
            check_value("cfg_done", 32'(cfg_done), 32'(exp_done));
            check_value("cfg_error", 32'(cfg_error), 32'(exp_error));
            check_value("scl", 32'(scl), 32'd1);
            check_value("sda_oe", 32'(sda_oe), 32'd0);
        end
        check_value("frame_count", 32'(frames_seen), 32'(exp_frames));
    endtask

    // --------------------
    // I2C slave model
    // --------------------
    always @(negedge clk) begin
        if (!rst_n) begin
            scl_prev    = 1'b1;
            line_prev   = 1'b1;
            pull        = 1'b0;
            in_ack      = 1'b0;
            in_frame    = 1'b0;
            shreg       = '0;
            frame_bytes = '0;
            bit_cnt     = 0;
            byte_cnt    = 0;
            frame_num   = 0;
            cap_bytes.delete();
            cap_len.delete();
            start_times.delete();
            stop_times.delete();
        end else begin
            // Wired-AND of master and slave
            line_now = !sda_oe && !pull;
            if (scl_prev && scl && line_prev && !line_now) begin
                // Start condition
                in_frame    = 1'b1;
                in_ack      = 1'b0;
                bit_cnt     = 0;
                byte_cnt    = 0;
                frame_bytes = '0;
                start_times.push_back($time);
            end else if (scl_prev && scl && !line_prev && line_now) begin
                // Stop condition closes the frame
                if (in_frame) begin
                    cap_bytes.push_back(frame_bytes);
                    cap_len.push_back(byte_cnt);
                    stop_times.push_back($time);
                    frame_num++;
                end
                in_frame = 1'b0;
            end else if (in_frame && !scl_prev && scl) begin
                // Data bit on rising SCL, ACK slot skipped
                if (!in_ack) begin
                    shreg = {shreg[6:0], line_now};
                    bit_cnt++;
                    if (bit_cnt == 8) begin
                        if (byte_cnt < 3) begin
                            frame_bytes[23 - 8 * byte_cnt -: 8] = shreg;
                        end
                        byte_cnt++;
                    end
                end
            end else if (in_frame && scl_prev && !scl) begin
                if (in_ack) begin
                    pull   = 1'b0;
                    in_ack = 1'b0;
                end else if (bit_cnt == 8) begin
                    // ACK unless this byte is the armed NACK
                    in_ack  = 1'b1;
                    bit_cnt = 0;
                    pull    = !(nack_armed && frame_num == nack_index &&
                                byte_cnt - 1 == nack_byte);
                end
            end
            scl_prev  = scl;
            line_prev = line_now;
        end
        sda_in <= !sda_oe && !pull;
    end

    // --------------------
    // Frame comparison
    // --------------------
    always @(posedge clk) begin
        logic [23:0] bytes;
        logic [15:0] exp_pair;
        int          len;
        int          exp_len;
        if (!rst_n) begin
            frames_seen = 0;
        end
        while (cap_len.size() > 0) begin
            bytes = cap_bytes.pop_front();
            len   = cap_len.pop_front();
            if (frames_seen > last_index) begin
                report_failure("A frame arrived after the sequence should have stopped");
            end
            exp_pair = expected_write(frames_seen);
            // NACKed frame stops after the refused byte
            exp_len  = (nack_armed && frames_seen == nack_index) ? nack_byte + 1 : 3;
            check_value("frame_len", 32'(len), 32'(exp_len));
            check_value("dev_byte", 32'(bytes[23:16]), 32'(`CODEC_I2C_ADDR) << 1);
            if (len >= 2) begin
                check_value("reg_addr", 32'(bytes[15:8]), 32'(exp_pair[15:8]));
            end
            if (len == 3) begin
                check_value("reg_data", 32'(bytes[7:0]), 32'(exp_pair[7:0]));
            end
            frames_seen++;
        end
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        sda_in     = 1'b1;
        nack_armed = 1'b0;
        nack_index = 0;
        nack_byte  = 0;
        last_index = NUM_WRITES - 1;
        seed       = 32'hd2fae0e4;

        // Full sequence, every byte acknowledged
        apply_reset();
        check_idle_outputs();
        wait_for_end();
        check_value("cfg_done", 32'(cfg_done), 32'd1);
        check_value("cfg_error", 32'(cfg_error), 32'd0);
        check_value("frame_count", 32'(frames_seen), 32'(NUM_WRITES));
        if ((start_times[0] - rel_time) / CLK_PERIOD < POWERUP) begin
            report_failure("A start condition appeared before the power-up delay ended");
        end
        gap = (start_times[2] - stop_times[1]) / CLK_PERIOD;
        if (gap < RESET_WAIT) begin
            report_failure($sformatf("Pause after the soft-reset release was only %0d cycles",
                                     gap));
        end
        watch_idle(1'b1, 1'b0, NUM_WRITES);

        // NACK on a random write and byte
        nack_index = $unsigned($random(seed)) % NUM_WRITES;
        nack_byte  = $unsigned($random(seed)) % 3;
        nack_armed = 1'b1;
        last_index = nack_index;
        apply_reset();
        check_idle_outputs();
        wait_for_end();
        check_value("cfg_error", 32'(cfg_error), 32'd1);
        check_value("cfg_done", 32'(cfg_done), 32'd0);
        check_value("frame_count", 32'(frames_seen), 32'(nack_index + 1));
        watch_idle(1'b0, 1'b1, nack_index + 1);

        // Bound checks flag their own failures
        if (i_dut.u_checks.failed) begin
            $display("Bound assertion failed during the run");
            $display("*** TEST FAILED ***");
            $fatal(1, "Simulation stopped after an assertion failure");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule
